/* rtl/lsu_pkg.sv */
package lsu_pkg;

  localparam int TAG_WIDTH    = 20;
  localparam int INDEX_WIDTH  = 8;
  localparam int OFFSET_WIDTH = 4;  // index + offset cover a 4 KB page

  typedef enum logic [3:0] {
    LD_B  = 4'h0,
    LD_H  = 4'h1,
    LD_W  = 4'h2,
    ST_B  = 4'h4,
    ST_H  = 4'h5,
    ST_W  = 4'h6,
    LD_BU = 4'h8,
    LD_HU = 4'h9
  } mem_funct_t;

  typedef struct packed {
    logic load;
    logic store;
    logic size_byte;
    logic size_half;
    logic size_word;
    logic load_sign;
  } mem_opcode_t;

  typedef enum logic [2:0] {
    ALE    = 3'd0,  // misaligned address
    D_TLBR = 3'd1,  // no tlb entry
    PIL    = 3'd2,
    PIS    = 3'd3,
    PPI    = 3'd4,
    PME    = 3'd5   // store to a clean page
  } excp_t;

endpackage

/* rtl/mem_op_decode.sv */
`timescale 1ns/1ps

module mem_op_decode (
  input  lsu_pkg::mem_funct_t  funct,
  output lsu_pkg::mem_opcode_t opcode
);

  always_comb begin
    opcode = '0;  // unknown codes leave every flag low
    case (funct)
      lsu_pkg::LD_B: begin
        opcode.load      = 1'b1;
        opcode.size_byte = 1'b1;
        opcode.load_sign = 1'b1;
      end
      lsu_pkg::LD_H: begin
        opcode.load      = 1'b1;
        opcode.size_half = 1'b1;
        opcode.load_sign = 1'b1;
      end
      lsu_pkg::LD_W: begin
        opcode.load      = 1'b1;
        opcode.size_word = 1'b1;
      end
      lsu_pkg::LD_BU: begin
        opcode.load      = 1'b1;
        opcode.size_byte = 1'b1;
      end
      lsu_pkg::LD_HU: begin
        opcode.load      = 1'b1;
        opcode.size_half = 1'b1;
      end
      lsu_pkg::ST_B: begin
        opcode.store     = 1'b1;
        opcode.size_byte = 1'b1;
      end
      lsu_pkg::ST_H: begin
        opcode.store     = 1'b1;
        opcode.size_half = 1'b1;
      end
      lsu_pkg::ST_W: begin
        opcode.store     = 1'b1;
        opcode.size_word = 1'b1;
      end
      default: opcode = '0;
    endcase
  end

endmodule

/* rtl/lsu.sv */
`timescale 1ns/1ps

module lsu (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  valid,
  input  lsu_pkg::mem_opcode_t                  opcode,
  input  logic [31:0]                           addr,
  input  logic [31:0]                           st_data,
  output logic                                  ready,
  output logic                                  mmu_valid,
  output logic [lsu_pkg::TAG_WIDTH-1:0]         mmu_vtag,
  input  logic                                  mmu_ok,
  input  logic [lsu_pkg::TAG_WIDTH-1:0]         mmu_ptag,
  input  logic                                  mmu_page_fault,
  input  logic                                  mmu_page_invalid,
  input  logic                                  mmu_page_clean,
  input  logic                                  mmu_plv_fault,
  output logic                                  dcache_valid,
  output logic                                  dcache_store,
  output logic [lsu_pkg::TAG_WIDTH-1:0]         dcache_tag,
  output logic [lsu_pkg::INDEX_WIDTH-1:0]       dcache_index,
  output logic [lsu_pkg::OFFSET_WIDTH-1:0]      dcache_offset,
  output logic [3:0]                            dcache_wstrb,
  output logic [31:0]                           dcache_wdata,
  input  logic                                  dcache_addr_ok,
  input  logic                                  dcache_data_ok,
  output logic                                  accept,
  output logic                                  have_excp,
  output lsu_pkg::excp_t                        excp_type,
  output lsu_pkg::mem_opcode_t                  opcode_q,
  output logic [1:0]                            addr_low_q,
  output logic                                  ok
);

  logic mmu_ok_reg;
  logic misaligned;
  logic translated;
  logic is_store;

  assign is_store   = opcode.store;
  assign translated = mmu_ok || mmu_ok_reg;

  // anything that is neither byte nor half is handled as a word
  assign misaligned = opcode.size_half ? addr[0] :
                      !opcode.size_byte && (addr[1:0] != 2'b00);

  assign ready  = valid && (have_excp || dcache_addr_ok && translated);
  assign accept = valid && ready;
  assign ok     = dcache_data_ok;

  // no new lookup while an answer is arriving or held
  assign mmu_valid = valid && !misaligned && !mmu_ok && !mmu_ok_reg;
  assign mmu_vtag  = addr[31 -: lsu_pkg::TAG_WIDTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      mmu_ok_reg <= 1'b0;
    end else if (accept) begin
      mmu_ok_reg <= 1'b0;
    end else if (mmu_ok) begin
      mmu_ok_reg <= 1'b1;  // memory busy, keep the translation
    end
  end

  // only memory accesses update the load context
  always_ff @(posedge clk) begin
    if (dcache_valid && dcache_addr_ok) begin
      opcode_q   <= opcode;
      addr_low_q <= addr[1:0];
    end
  end

  assign dcache_valid  = valid && !have_excp && translated;
  assign dcache_store  = is_store;
  assign dcache_tag    = mmu_ptag;
  assign dcache_index  = addr[lsu_pkg::OFFSET_WIDTH +: lsu_pkg::INDEX_WIDTH];
  assign dcache_offset = addr[lsu_pkg::OFFSET_WIDTH-1:0];

  always_comb begin
    if (opcode.size_byte) begin
      dcache_wstrb = 4'b0001 << addr[1:0];
      dcache_wdata = {4{st_data[7:0]}};
    end else if (opcode.size_half) begin
      dcache_wstrb = addr[1] ? 4'b1100 : 4'b0011;
      dcache_wdata = {2{st_data[15:0]}};
    end else begin
      dcache_wstrb = 4'b1111;
      dcache_wdata = st_data;
    end
  end

  // tlb flags are only nonzero in the mmu_ok cycle
  always_comb begin
    have_excp = 1'b0;
    excp_type = lsu_pkg::ALE;
    if (valid) begin
      if (misaligned) begin
        have_excp = 1'b1;
        excp_type = lsu_pkg::ALE;
      end else if (mmu_page_fault) begin
        have_excp = 1'b1;
        excp_type = lsu_pkg::D_TLBR;
      end else if (mmu_page_invalid) begin
        have_excp = 1'b1;
        excp_type = is_store ? lsu_pkg::PIS : lsu_pkg::PIL;
      end else if (mmu_plv_fault) begin
        have_excp = 1'b1;
        excp_type = lsu_pkg::PPI;
      end else if (mmu_page_clean && is_store) begin
        have_excp = 1'b1;
        excp_type = lsu_pkg::PME;
      end
    end
  end

endmodule

/* rtl/lsu_result.sv */
`timescale 1ns/1ps

module lsu_result (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 accept,
  input  logic                 have_excp,
  input  lsu_pkg::excp_t       excp_type,
  input  lsu_pkg::mem_opcode_t opcode_q,
  input  logic [1:0]           addr_low_q,
  input  logic                 ok,
  input  logic [31:0]          rdata,
  output logic                 wb_valid,
  output logic [31:0]          wb_data,
  output logic                 excp_valid,
  output lsu_pkg::excp_t       excp_code
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic [31:0] ld_data;

  assign ld_byte = rdata[8*addr_low_q +: 8];
  assign ld_half = addr_low_q[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    if (opcode_q.store) begin
      ld_data = rdata;  // old word
    end else if (opcode_q.size_byte) begin
      ld_data = {{24{ld_byte[7] && opcode_q.load_sign}}, ld_byte};
    end else if (opcode_q.size_half) begin
      ld_data = {{16{ld_half[15] && opcode_q.load_sign}}, ld_half};
    end else begin
      ld_data = rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid   <= 1'b0;
      excp_valid <= 1'b0;
    end else begin
      wb_valid   <= ok;
      excp_valid <= accept && have_excp;
    end
  end

  always_ff @(posedge clk) begin
    if (ok) wb_data <= ld_data;
    if (accept && have_excp) excp_code <= excp_type;
  end

endmodule

/* rtl/dtlb.sv */
`timescale 1ns/1ps

module dtlb #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           tlb_we,
  input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
  input  logic [lsu_pkg::TAG_WIDTH-1:0]  tlb_vtag,
  input  logic [lsu_pkg::TAG_WIDTH-1:0]  tlb_ptag,
  input  logic                           tlb_v,
  input  logic                           tlb_d,
  input  logic [1:0]                     tlb_plv,
  input  logic [1:0]                     cur_plv,
  input  logic                           mmu_valid,
  input  logic [lsu_pkg::TAG_WIDTH-1:0]  mmu_vtag,
  output logic                           mmu_ok,
  output logic [lsu_pkg::TAG_WIDTH-1:0]  mmu_ptag,
  output logic                           mmu_page_fault,
  output logic                           mmu_page_invalid,
  output logic                           mmu_page_clean,
  output logic                           mmu_plv_fault
);

  logic [TLB_ENTRIES-1:0]              present;
  logic [lsu_pkg::TAG_WIDTH-1:0]       vtag_mem [TLB_ENTRIES];
  logic [lsu_pkg::TAG_WIDTH-1:0]       ptag_mem [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0]              v_mem;
  logic [TLB_ENTRIES-1:0]              d_mem;
  logic [1:0]                          plv_mem [TLB_ENTRIES];
  logic                                hit;
  logic [$clog2(TLB_ENTRIES)-1:0]      hit_idx;
  logic                                fault_q, invalid_q, clean_q, plv_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      present <= '0;
    end else if (tlb_we) begin
      present[tlb_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tlb_we) begin
      vtag_mem[tlb_index] <= tlb_vtag;
      ptag_mem[tlb_index] <= tlb_ptag;
      v_mem[tlb_index]    <= tlb_v;
      d_mem[tlb_index]    <= tlb_d;
      plv_mem[tlb_index]  <= tlb_plv;
    end
  end

  // scan downwards so the lowest matching index wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (present[i] && vtag_mem[i] == mmu_vtag) begin
        hit     = 1'b1;
        hit_idx = i[$clog2(TLB_ENTRIES)-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) mmu_ok <= 1'b0;
    else       mmu_ok <= mmu_valid;
  end

  // ptag stays put between lookups
  always_ff @(posedge clk) begin
    if (mmu_valid) begin
      mmu_ptag  <= ptag_mem[hit_idx];
      fault_q   <= !hit;
      invalid_q <= hit && !v_mem[hit_idx];
      clean_q   <= hit && !d_mem[hit_idx];
      plv_q     <= hit && (plv_mem[hit_idx] < cur_plv);
    end
  end

  assign mmu_page_fault   = mmu_ok && fault_q;
  assign mmu_page_invalid = mmu_ok && invalid_q;
  assign mmu_page_clean   = mmu_ok && clean_q;
  assign mmu_plv_fault    = mmu_ok && plv_q;

endmodule

/* rtl/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_WORDS   = 1024,
  parameter int MEM_LATENCY = 2
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              dcache_valid,
  input  logic                              dcache_store,
  input  logic [lsu_pkg::TAG_WIDTH-1:0]     dcache_tag,
  input  logic [lsu_pkg::INDEX_WIDTH-1:0]   dcache_index,
  input  logic [lsu_pkg::OFFSET_WIDTH-1:0]  dcache_offset,
  input  logic [3:0]                        dcache_wstrb,
  input  logic [31:0]                       dcache_wdata,
  output logic                              dcache_addr_ok,
  output logic                              dcache_data_ok,
  output logic [31:0]                       dcache_rdata
);

  localparam int ADDR_W = $clog2(RAM_WORDS);
  localparam int CNT_W  = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
  localparam int FULL_W = lsu_pkg::TAG_WIDTH + lsu_pkg::INDEX_WIDTH + lsu_pkg::OFFSET_WIDTH - 2;

  logic [31:0]       mem [RAM_WORDS];
  logic [FULL_W-1:0] full_addr;
  logic [ADDR_W-1:0] word_addr;
  logic              busy;
  logic [CNT_W-1:0]  cnt;
  logic              take;

  assign full_addr = {dcache_tag, dcache_index, dcache_offset[lsu_pkg::OFFSET_WIDTH-1:2]};
  assign word_addr = full_addr[ADDR_W-1:0];

  assign dcache_data_ok = busy && (cnt == '0);
  assign dcache_addr_ok = !busy || (cnt == '0);  // free again as data returns
  assign take           = dcache_valid && dcache_addr_ok;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (take) begin
      busy <= 1'b1;
      cnt  <= CNT_W'(MEM_LATENCY - 1);
    end else if (busy) begin
      if (cnt == '0) busy <= 1'b0;
      else           cnt  <= cnt - 1'b1;
    end
  end

  // read the old word and merge strobed bytes in one edge
  always_ff @(posedge clk) begin
    if (take) begin
      dcache_rdata <= mem[word_addr];
      for (int b = 0; b < 4; b++) begin
        if (dcache_store && dcache_wstrb[b]) mem[word_addr][8*b +: 8] <= dcache_wdata[8*b +: 8];
      end
    end
  end

endmodule

/* rtl/mem_subsys.sv */
`timescale 1ns/1ps

module mem_subsys #(
  parameter int TLB_ENTRIES = 4,
  parameter int RAM_WORDS   = 1024,
  parameter int MEM_LATENCY = 2
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           req_valid,
  input  lsu_pkg::mem_funct_t            req_funct,
  input  logic [31:0]                    req_addr,
  input  logic [31:0]                    req_st_data,
  input  logic [1:0]                     cur_plv,
  input  logic                           tlb_we,
  input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
  input  logic [lsu_pkg::TAG_WIDTH-1:0]  tlb_vtag,
  input  logic [lsu_pkg::TAG_WIDTH-1:0]  tlb_ptag,
  input  logic                           tlb_v,
  input  logic                           tlb_d,
  input  logic [1:0]                     tlb_plv,
  output logic                           req_ready,
  output logic                           wb_valid,
  output logic [31:0]                    wb_data,
  output logic                           excp_valid,
  output lsu_pkg::excp_t                 excp_code
);

  lsu_pkg::mem_opcode_t opcode, opcode_q;
  lsu_pkg::excp_t       excp_type;

  logic                               mmu_valid, mmu_ok;
  logic [lsu_pkg::TAG_WIDTH-1:0]      mmu_vtag, mmu_ptag;
  logic                               mmu_page_fault, mmu_page_invalid;
  logic                               mmu_page_clean, mmu_plv_fault;
  logic                               dcache_valid, dcache_store;
  logic [lsu_pkg::TAG_WIDTH-1:0]      dcache_tag;
  logic [lsu_pkg::INDEX_WIDTH-1:0]    dcache_index;
  logic [lsu_pkg::OFFSET_WIDTH-1:0]   dcache_offset;
  logic [3:0]                         dcache_wstrb;
  logic [31:0]                        dcache_wdata, dcache_rdata;
  logic                               dcache_addr_ok, dcache_data_ok;
  logic                               accept, have_excp, ok;
  logic [1:0]                         addr_low_q;

  mem_op_decode i_decode (.funct(req_funct), .opcode(opcode));

  lsu i_lsu (
    .clk, .reset, .valid(req_valid), .opcode, .addr(req_addr), .st_data(req_st_data),
    .ready(req_ready), .mmu_valid, .mmu_vtag, .mmu_ok, .mmu_ptag, .mmu_page_fault,
    .mmu_page_invalid, .mmu_page_clean, .mmu_plv_fault, .dcache_valid, .dcache_store,
    .dcache_tag, .dcache_index, .dcache_offset, .dcache_wstrb, .dcache_wdata,
    .dcache_addr_ok, .dcache_data_ok, .accept, .have_excp, .excp_type, .opcode_q,
    .addr_low_q, .ok
  );

  dtlb #(.TLB_ENTRIES(TLB_ENTRIES)) i_dtlb (
    .clk, .reset, .tlb_we, .tlb_index, .tlb_vtag, .tlb_ptag, .tlb_v, .tlb_d, .tlb_plv,
    .cur_plv, .mmu_valid, .mmu_vtag, .mmu_ok, .mmu_ptag, .mmu_page_fault,
    .mmu_page_invalid, .mmu_page_clean, .mmu_plv_fault
  );

  data_ram #(.RAM_WORDS(RAM_WORDS), .MEM_LATENCY(MEM_LATENCY)) i_ram (
    .clk, .reset, .dcache_valid, .dcache_store, .dcache_tag, .dcache_index,
    .dcache_offset, .dcache_wstrb, .dcache_wdata, .dcache_addr_ok, .dcache_data_ok,
    .dcache_rdata
  );

  lsu_result i_result (
    .clk, .reset, .accept, .have_excp, .excp_type, .opcode_q, .addr_low_q, .ok,
    .rdata(dcache_rdata), .wb_valid, .wb_data, .excp_valid, .excp_code
  );

endmodule

/* test/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

  localparam int PERIOD  = 100;
  localparam int TIMEOUT = 50;  // cycles per wait

  logic                 clk;
  logic                 reset;
  logic                 req_valid;
  lsu_pkg::mem_funct_t  req_funct;
  logic [31:0]          req_addr;
  logic [31:0]          req_st_data;
  logic [1:0]           cur_plv;
  logic                 tlb_we;
  logic [2:0]           tlb_index;
  logic [19:0]          tlb_vtag;
  logic [19:0]          tlb_ptag;
  logic                 tlb_v;
  logic                 tlb_d;
  logic [1:0]           tlb_plv;
  logic                 req_ready;
  logic                 wb_valid;
  logic [31:0]          wb_data;
  logic                 excp_valid;
  lsu_pkg::excp_t       excp_code;

  logic [7:0]           model [4096];  // bytes by page offset for odd ptags
  logic [31:0]          wb_exp_q [$];
  bit                   wb_chk_q [$];
  string                wb_name_q [$];
  lsu_pkg::excp_t       ex_exp_q [$];
  string                ex_name_q [$];
  string                test_name;
  int                   errors, checks, tests, seed;

  mem_subsys #(.TLB_ENTRIES(8), .RAM_WORDS(2048), .MEM_LATENCY(2)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  task automatic fail_now(input string why);
    $display("%s (test %s)", why, test_name);
    $display("Simulation FAILED");
    $finish;
  endtask

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    logic [11:0] a;
    a = {addr[11:2], 2'b00};
    return {model[a+3], model[a+2], model[a+1], model[a]};
  endfunction

  function automatic logic [31:0] load_value(input lsu_pkg::mem_funct_t f,
                                             input logic [31:0] addr);
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    w = model_word(addr);
    b = w[8*addr[1:0] +: 8];
    h = addr[1] ? w[31:16] : w[15:0];
    case (f)
      lsu_pkg::LD_B:  return {{24{b[7]}}, b};
      lsu_pkg::LD_BU: return {24'h0, b};
      lsu_pkg::LD_H:  return {{16{h[15]}}, h};
      lsu_pkg::LD_HU: return {16'h0, h};
      default:        return w;  // word load, and old word for stores
    endcase
  endfunction

  task automatic apply_store(input lsu_pkg::mem_funct_t f, input logic [31:0] addr,
                             input logic [31:0] data);
    logic [11:0] a;
    a = addr[11:0];
    if (f == lsu_pkg::ST_B) begin
      model[a] = data[7:0];
    end else if (f == lsu_pkg::ST_H) begin
      model[a]   = data[7:0];
      model[a+1] = data[15:8];
    end else if (f == lsu_pkg::ST_W) begin
      for (int i = 0; i < 4; i++) model[a+i] = data[8*i +: 8];
    end
  endtask

  // hold the request until req_ready, then record what must come back
  task automatic issue_req(input lsu_pkg::mem_funct_t f, input logic [31:0] addr,
                           input logic [31:0] data, input bit has_ex,
                           input lsu_pkg::excp_t code, input bit chk);
    int n;
    n = 0;
    req_valid   = 1'b1;
    req_funct   = f;
    req_addr    = addr;
    req_st_data = data;
    @(negedge clk);
    while (!req_ready) begin
      n++;
      if (n > TIMEOUT) fail_now("timeout waiting for req_ready");
      @(negedge clk);
    end
    if (has_ex) begin
      ex_exp_q.push_back(code);
      ex_name_q.push_back(test_name);
    end else begin
      wb_exp_q.push_back(load_value(f, addr));
      wb_chk_q.push_back(chk);
      wb_name_q.push_back(test_name);
      apply_store(f, addr, data);
    end
    @(posedge clk);
    #10;
    req_valid = 1'b0;
  endtask

  task automatic drain_and_report();
    int n;
    n = 0;
    while (wb_exp_q.size() != 0 || ex_exp_q.size() != 0) begin
      n++;
      if (n > TIMEOUT) fail_now("timeout waiting for wb_valid or excp_valid");
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    #10;
    tests++;
    $display("test %-10s done, errors so far %0d", test_name, errors);
  endtask

  task automatic tlb_write(input int idx, input logic [19:0] vt, input logic [19:0] pt,
                           input bit v, input bit d, input logic [1:0] plv);
    tlb_we    = 1'b1;
    tlb_index = idx[2:0];
    tlb_vtag  = vt;
    tlb_ptag  = pt;
    tlb_v     = v;
    tlb_d     = d;
    tlb_plv   = plv;
    @(posedge clk);
    #10;
    tlb_we = 1'b0;
  endtask

  // results are checked as they pulse, in order of acceptance
  always @(negedge clk) begin
    if (!reset) begin
      if (wb_valid) begin
        if (wb_exp_q.size() == 0) begin
          $display("unexpected wb_valid pulse in test %s", test_name);
          errors++;
        end else begin
          checks++;
          if (wb_chk_q[0]) begin
            assert (wb_data === wb_exp_q[0]) else begin
              $display("ERR %s wb_data expected %08h actual %08h", wb_name_q[0],
                       wb_exp_q[0], wb_data);
              errors++;
            end
          end
          void'(wb_exp_q.pop_front());
          void'(wb_chk_q.pop_front());
          void'(wb_name_q.pop_front());
        end
      end
      if (excp_valid) begin
        if (ex_exp_q.size() == 0) begin
          $display("unexpected excp_valid pulse (%s) in test %s", excp_code.name(), test_name);
          errors++;
        end else begin
          checks++;
          assert (excp_code === ex_exp_q[0]) else begin
            $display("ERR %s excp_code expected %s actual %s", ex_name_q[0],
                     ex_exp_q[0].name(), excp_code.name());
            errors++;
          end
          void'(ex_exp_q.pop_front());
          void'(ex_name_q.pop_front());
        end
      end
    end
  end

  function automatic logic [31:0] va(input logic [19:0] vt, input int off);
    return {vt, off[11:0]};
  endfunction

  initial begin
    lsu_pkg::mem_funct_t f;
    logic [19:0]         pg;
    int                  r, off;
    errors = 0;
    checks = 0;
    tests  = 0;
    seed   = 56160;
    test_name   = "reset";
    reset       = 1'b1;
    req_valid   = 1'b0;
    req_funct   = lsu_pkg::LD_W;
    req_addr    = '0;
    req_st_data = '0;
    cur_plv     = 2'd3;
    tlb_we      = 1'b0;
    tlb_index   = '0;
    tlb_vtag    = '0;
    tlb_ptag    = '0;
    tlb_v       = 1'b0;
    tlb_d       = 1'b0;
    tlb_plv     = '0;
    repeat (8) @(posedge clk);
    #10;
    reset = 1'b0;
    assert (!req_ready && !wb_valid && !excp_valid) else begin
      $display("outputs not idle after reset");
      errors++;
    end

    tlb_write(0, 20'h00010, 20'h00101, 1, 1, 2'd3);
    tlb_write(1, 20'h00020, 20'h00101, 1, 1, 2'd3);  // alias of page 0
    tlb_write(2, 20'h00030, 20'h00201, 0, 1, 2'd3);
    tlb_write(3, 20'h00040, 20'h00300, 1, 1, 2'd0);
    tlb_write(4, 20'h00050, 20'h00401, 1, 0, 2'd3);

    test_name = "fill";
    for (int i = 0; i < 16; i++) begin
      issue_req(lsu_pkg::ST_W, va(20'h00010, 4*i), 32'h5a00_0000 | (i * 32'h0001_0104),
                0, lsu_pkg::ALE, 0);
    end
    drain_and_report();

    test_name = "word";
    issue_req(lsu_pkg::ST_W, va(20'h00010, 8), 32'hdead_beef, 0, lsu_pkg::ALE, 1);
    issue_req(lsu_pkg::LD_W, va(20'h00010, 8), 0, 0, lsu_pkg::ALE, 1);
    drain_and_report();

    test_name = "subword";
    issue_req(lsu_pkg::ST_W, va(20'h00010, 12), 32'h80f1_7f82, 0, lsu_pkg::ALE, 1);
    for (int i = 0; i < 4; i++) begin
      issue_req(lsu_pkg::LD_B, va(20'h00010, 12 + i), 0, 0, lsu_pkg::ALE, 1);
      issue_req(lsu_pkg::LD_BU, va(20'h00010, 12 + i), 0, 0, lsu_pkg::ALE, 1);
    end
    for (int i = 0; i < 4; i += 2) begin
      issue_req(lsu_pkg::LD_H, va(20'h00010, 12 + i), 0, 0, lsu_pkg::ALE, 1);
      issue_req(lsu_pkg::LD_HU, va(20'h00010, 12 + i), 0, 0, lsu_pkg::ALE, 1);
    end
    issue_req(lsu_pkg::ST_B, va(20'h00010, 13), 32'h0000_00a5, 0, lsu_pkg::ALE, 1);
    issue_req(lsu_pkg::ST_H, va(20'h00010, 14), 32'h0000_c3d4, 0, lsu_pkg::ALE, 1);
    issue_req(lsu_pkg::LD_W, va(20'h00010, 12), 0, 0, lsu_pkg::ALE, 1);
    drain_and_report();

    test_name = "align";
    issue_req(lsu_pkg::LD_H, va(20'h00010, 5), 0, 1, lsu_pkg::ALE, 1);
    issue_req(lsu_pkg::ST_W, va(20'h00010, 18), 32'h1111_2222, 1, lsu_pkg::ALE, 1);
    issue_req(lsu_pkg::LD_W, va(20'h00010, 17), 0, 1, lsu_pkg::ALE, 1);
    issue_req(lsu_pkg::LD_W, va(20'h00010, 16), 0, 0, lsu_pkg::ALE, 1);
    drain_and_report();

    test_name = "page";
    issue_req(lsu_pkg::LD_W, va(20'h00099, 0), 0, 1, lsu_pkg::D_TLBR, 1);
    issue_req(lsu_pkg::LD_W, va(20'h00030, 4), 0, 1, lsu_pkg::PIL, 1);
    issue_req(lsu_pkg::ST_W, va(20'h00030, 4), 32'h7777_0000, 1, lsu_pkg::PIS, 1);
    issue_req(lsu_pkg::LD_W, va(20'h00040, 4), 0, 1, lsu_pkg::PPI, 1);
    issue_req(lsu_pkg::ST_H, va(20'h00050, 4), 32'h0000_9999, 1, lsu_pkg::PME, 1);
    issue_req(lsu_pkg::LD_W, va(20'h00050, 4), 0, 0, lsu_pkg::ALE, 1);
    drain_and_report();

    test_name = "alias";
    issue_req(lsu_pkg::ST_W, va(20'h00010, 20), 32'h0a1a_5a5a, 0, lsu_pkg::ALE, 1);
    issue_req(lsu_pkg::LD_W, va(20'h00020, 20), 0, 0, lsu_pkg::ALE, 1);
    drain_and_report();

    test_name = "random";
    for (int i = 0; i < 80; i++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0: f = lsu_pkg::LD_B;
        3'd1: f = lsu_pkg::LD_H;
        3'd2: f = lsu_pkg::LD_W;
        3'd3: f = lsu_pkg::ST_B;
        3'd4: f = lsu_pkg::ST_H;
        3'd5: f = lsu_pkg::ST_W;
        3'd6: f = lsu_pkg::LD_BU;
        default: f = lsu_pkg::LD_HU;
      endcase
      off = 4 * r[7:4];
      if (f == lsu_pkg::LD_B || f == lsu_pkg::LD_BU || f == lsu_pkg::ST_B) off += r[9:8];
      else if (f == lsu_pkg::LD_H || f == lsu_pkg::LD_HU || f == lsu_pkg::ST_H) off += 2 * r[8];
      // the clean page only takes loads
      if (r[11:10] == 2'd3 && (f != lsu_pkg::ST_B && f != lsu_pkg::ST_H && f != lsu_pkg::ST_W))
        pg = 20'h00050;
      else
        pg = r[10] ? 20'h00020 : 20'h00010;
      issue_req(f, va(pg, off), $random(seed), 0, lsu_pkg::ALE, 1);
    end
    drain_and_report();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
rtl/lsu_pkg.sv
rtl/mem_op_decode.sv
rtl/lsu.sv
rtl/lsu_result.sv
rtl/dtlb.sv
rtl/data_ram.sv
rtl/mem_subsys.sv
test/tb_mem_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -Wno-fatal
FILELIST  ?= sim.f

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
